/* files.f */
source/periph_pkg.sv
source/periph_bus_decode.sv
source/periph_read_buffer.sv
source/gpio_ctrl.sv
source/timer_periph.sv
source/edge_counter_periph.sv
source/pwm_periph.sv
source/periph_top.sv
verification/periph_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert -Wno-fatal -j 0
TOP       = periph_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@grep -q "TESTBENCH PASSED" $(LOG) || { echo "Simulation did not complete"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/periph_tb.sv */
module periph_tb
    import periph_pkg::*;
();

    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    localparam int PWM_WINDOW = 260;   // Longer than one PWM period
    localparam int TIMER_CMP  = 40;

    // Expected cycles of the reset and of each test in run order
    localparam int TEST_CYCLES = 10 + 10 + 30 + (2 * PWM_WINDOW + 60) + 60
                               + (TIMER_CMP + 60) + 80;
    localparam int CYCLE_LIMIT = 10 * TEST_CYCLES;

    logic              clk;
    logic              rst_n;
    logic [ADDR_W-1:0] i_addr;
    logic [DATA_W-1:0] i_data;
    logic [1:0]        i_write_n;
    logic [1:0]        i_read_n;
    logic              i_read_complete;
    logic [7:0]        i_ui_in;
    logic [DATA_W-1:0] o_data;
    logic              o_data_ready;
    logic [7:0]        o_uo_out;
    logic              o_audio;
    logic              o_audio_select;
    logic              o_irq;

    int          checks      = 0;
    int          errors      = 0;
    int          cycle_count = 0;
    logic [31:0] lfsr_state  = 32'he29d;

    periph_top dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_addr          (i_addr),
        .i_data          (i_data),
        .i_write_n       (i_write_n),
        .i_read_n        (i_read_n),
        .i_read_complete (i_read_complete),
        .i_ui_in         (i_ui_in),
        .o_data          (o_data),
        .o_data_ready    (o_data_ready),
        .o_uo_out        (o_uo_out),
        .o_audio         (o_audio),
        .o_audio_select  (o_audio_select),
        .o_irq           (o_irq)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Region bit 0, slot, 6-bit offset
    function automatic logic [ADDR_W-1:0] full_addr(input logic [3:0] slot,
                                                    input logic [5:0] offset);
        return {1'b0, slot, offset};
    endfunction

    // Region 2, spare bit, slot, 4-bit offset
    function automatic logic [ADDR_W-1:0] byte_addr(input logic [3:0] slot,
                                                    input logic [3:0] offset);
        return {2'b10, 1'b0, slot, offset};
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'hA300_0000;   // x^32 + x^30 + x^26 + x^25 + 1
        end
        return next;
    endfunction

    task automatic random_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAILED at %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Error at %0t: %s", $time, what);
        end
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic [1:0] size);
        @(posedge clk);
        i_addr    <= addr;
        i_data    <= data;
        i_write_n <= size;
        @(negedge clk);
        check_true(o_data_ready, "write was not acknowledged in its own cycle");
        @(posedge clk);
        i_write_n <= SIZE_NONE;
    endtask

    // Latency counts clock edges from the request to o_data_ready
    task automatic bus_read(input logic [ADDR_W-1:0] addr, input logic [1:0] size,
                            output logic [31:0] data, output int latency);
        latency = 0;
        @(posedge clk);
        i_addr   <= addr;
        i_read_n <= size;
        @(negedge clk);
        while (!o_data_ready) begin
            latency++;
            @(negedge clk);
        end
        data = o_data;
        @(posedge clk);
        i_read_n        <= SIZE_NONE;
        i_read_complete <= 1'b1;
        @(posedge clk);
        i_read_complete <= 1'b0;
    endtask

    task automatic read_expect(input string name, input logic [ADDR_W-1:0] addr,
                               input logic [1:0] size, input logic [31:0] expected,
                               input int exp_latency);
        logic [31:0] value;
        int          latency;
        bus_read(addr, size, value, latency);
        check_value(name, expected, value);
        check_value({name, " latency"}, 32'(exp_latency), 32'(latency));
    endtask

    task automatic report_test(input string name, input int err_start);
        if (errors == err_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_start);
        end
    endtask

    // No ready while the bus is idle
    always @(negedge clk) begin
        if (rst_n && i_read_n == SIZE_NONE && i_write_n == SIZE_NONE) begin
            assert (!o_data_ready) else begin
                errors++;
                $display("FAILED at %0t: o_data_ready expected 0x0, got 0x1", $time);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin : main_seq
        logic [31:0]       rnd;
        logic [7:0]        gpio_val;
        logic [7:0]        ui_val;
        logic [31:0]       rdata;
        logic [31:0]       keep_vals [5];
        logic [ADDR_W-1:0] keep_addr [5];
        int                err_start;
        int                k;
        int                waited;
        int                lat;

        rst_n           = 1'b0;
        i_addr          = '0;
        i_data          = '0;
        i_write_n       = SIZE_NONE;
        i_read_n        = SIZE_NONE;
        i_read_complete = 1'b0;
        i_ui_in         = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        err_start = errors;
        @(negedge clk);
        check_value("o_uo_out", 32'd0, 32'(o_uo_out));
        check_value("o_irq", 32'd0, 32'(o_irq));
        check_value("o_audio_select", 32'd0, 32'(o_audio_select));
        repeat (4) begin
            @(negedge clk);
            check_value("o_data_ready", 32'd0, 32'(o_data_ready));
        end
        report_test("reset state", err_start);

        err_start = errors;
        random_bits(8, rnd);
        gpio_val = rnd[7:0];
        bus_write(full_addr(4'(SLOT_GPIO), GPIO_OFS_OUT), 32'(gpio_val), SIZE_WORD);
        @(negedge clk);
        check_value("o_uo_out", 32'(gpio_val), 32'(o_uo_out));
        read_expect("gpio out", full_addr(4'(SLOT_GPIO), GPIO_OFS_OUT), SIZE_WORD,
                    32'(gpio_val), 1);
        random_bits(8, rnd);
        ui_val = rnd[7:0];
        @(posedge clk);
        i_ui_in <= ui_val;
        read_expect("gpio in", full_addr(4'(SLOT_GPIO), GPIO_OFS_IN), SIZE_WORD,
                    32'(ui_val), 1);
        report_test("gpio", err_start);

        err_start = errors;
        bus_write(full_addr(4'(SLOT_GPIO), GPIO_OFS_FUNC_BASE), 32'(FUNC_PWM), SIZE_WORD);
        bus_write(full_addr(4'(SLOT_GPIO), GPIO_OFS_AUDIO), 32'({1'b1, AUDIO_SRC_PWM}),
                  SIZE_WORD);
        read_expect("pin 0 function", full_addr(4'(SLOT_GPIO), GPIO_OFS_FUNC_BASE),
                    SIZE_WORD, 32'(FUNC_PWM), 1);
        bus_write(byte_addr(4'(SLOT_PWM), 4'h0), 32'd0, SIZE_BYTE);
        repeat (2) @(negedge clk);   // Audio lags by one cycle
        for (int i = 0; i < PWM_WINDOW; i++) begin
            @(negedge clk);
            check_value("o_uo_out[0]", 32'd0, 32'(o_uo_out[0]));
            check_value("o_audio", 32'd0, 32'(o_audio));
        end
        bus_write(byte_addr(4'(SLOT_PWM), 4'h0), 32'd255, SIZE_BYTE);
        repeat (2) @(negedge clk);
        for (int i = 0; i < PWM_WINDOW; i++) begin
            @(negedge clk);
            check_value("o_uo_out[0]", 32'd1, 32'(o_uo_out[0]));
            check_value("o_audio", 32'd1, 32'(o_audio));
        end
        check_value("o_audio_select", 32'd1, 32'(o_audio_select));
        report_test("pwm and audio", err_start);

        err_start = errors;
        @(posedge clk);
        i_ui_in <= 8'h00;
        bus_write(byte_addr(4'(SLOT_EDGE), 4'h0), 32'd3, SIZE_BYTE);   // Watch pin 3
        bus_write(byte_addr(4'(SLOT_EDGE), 4'h1), 32'd0, SIZE_BYTE);
        random_bits(3, rnd);
        k = 2 + int'(rnd[2:0]);
        repeat (k) begin
            @(posedge clk);
            i_ui_in <= 8'h08;
            @(posedge clk);
            i_ui_in <= 8'hF7;                 // Other pins rise here
        end
        @(posedge clk);
        i_ui_in <= 8'h00;
        read_expect("edge count", byte_addr(4'(SLOT_EDGE), 4'h1), SIZE_BYTE, 32'(k), 1);
        bus_write(byte_addr(4'(SLOT_EDGE), 4'h1), 32'd0, SIZE_BYTE);
        read_expect("edge count after clear", byte_addr(4'(SLOT_EDGE), 4'h1), SIZE_BYTE,
                    32'd0, 1);
        report_test("edge counter", err_start);

        err_start = errors;
        bus_write(full_addr(4'(SLOT_TIMER), 6'h08), 32'd0, SIZE_WORD);
        bus_write(full_addr(4'(SLOT_TIMER), 6'h04), 32'(TIMER_CMP), SIZE_WORD);
        bus_write(full_addr(4'(SLOT_TIMER), 6'h00), 32'd1, SIZE_WORD);
        waited = 0;
        while (!o_irq && waited < TIMER_CMP + 20) begin
            @(negedge clk);
            waited++;
        end
        check_true(o_irq, "timer interrupt did not rise after the compare value");
        bus_read(full_addr(4'(SLOT_TIMER), 6'h08), SIZE_WORD, rdata, lat);
        check_value("timer read latency", 32'd2, 32'(lat));
        checks++;
        assert (rdata >= TIMER_CMP) else begin
            errors++;
            $display("FAILED at %0t: timer count expected >= 0x%0h, got 0x%0h",
                     $time, TIMER_CMP, rdata);
        end
        bus_write(full_addr(4'(SLOT_TIMER), 6'h00), 32'd2, SIZE_WORD);   // Stop and clear
        @(negedge clk);
        check_value("o_irq", 32'd0, 32'(o_irq));
        read_expect("timer control", full_addr(4'(SLOT_TIMER), 6'h00), SIZE_WORD, 32'd0, 2);
        report_test("timer", err_start);

        err_start = errors;
        keep_addr[0] = full_addr(4'(SLOT_GPIO), GPIO_OFS_OUT);
        keep_addr[1] = full_addr(4'(SLOT_GPIO), GPIO_OFS_FUNC_BASE);
        keep_addr[2] = full_addr(4'(SLOT_TIMER), 6'h04);
        keep_addr[3] = byte_addr(4'(SLOT_EDGE), 4'h0);
        keep_addr[4] = byte_addr(4'(SLOT_PWM), 4'h0);
        keep_vals[0] = 32'(gpio_val);
        keep_vals[1] = 32'(FUNC_PWM);
        keep_vals[2] = 32'(TIMER_CMP);
        keep_vals[3] = 32'd3;                 // Edge pin select
        keep_vals[4] = 32'd255;               // Last PWM duty
        read_expect("empty full slot", full_addr(4'd5, 6'h00), SIZE_WORD, 32'd0, 1);
        read_expect("empty byte slot", byte_addr(4'd7, 4'h0), SIZE_BYTE, 32'd0, 1);
        random_bits(32, rnd);
        bus_write(full_addr(4'd5, 6'h00), rnd, SIZE_WORD);
        bus_write(full_addr(4'd5, GPIO_OFS_FUNC_BASE), rnd, SIZE_WORD);
        bus_write(byte_addr(4'd7, 4'h0), rnd, SIZE_BYTE);
        for (int i = 0; i < 5; i++) begin
            bus_read(keep_addr[i], (keep_addr[i][10:9] == 2'b10) ? SIZE_BYTE : SIZE_WORD,
                     rdata, lat);
            check_value($sformatf("o_data at 0x%03h", keep_addr[i]), keep_vals[i], rdata);
        end
        report_test("empty slots", err_start);

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* source/periph_top.sv */
module periph_top
    import periph_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [ADDR_W-1:0] i_addr,
    input  logic [DATA_W-1:0] i_data,
    input  logic [1:0]        i_write_n,
    input  logic [1:0]        i_read_n,
    input  logic              i_read_complete,
    input  logic [7:0]        i_ui_in,
    output logic [DATA_W-1:0] o_data,
    output logic              o_data_ready,
    output logic [7:0]        o_uo_out,
    output logic              o_audio,
    output logic              o_audio_select,
    output logic              o_irq
);

    logic [1:0]        gpio_write_n;
    logic [1:0]        gpio_read_n;
    logic [1:0]        timer_write_n;
    logic [1:0]        timer_read_n;
    logic              edge_write;
    logic              pwm_write;
    logic [DATA_W-1:0] gpio_data;
    logic              gpio_ready;
    logic [DATA_W-1:0] timer_data;
    logic              timer_ready;
    logic [7:0]        edge_data;
    logic [7:0]        pwm_data;
    logic [DATA_W-1:0] periph_data;
    logic              periph_ready;
    logic              data_busy;
    logic [7:0]        timer_pins;
    logic [7:0]        edge_pins;
    logic [7:0]        pwm_pins;

    periph_bus_decode u_decode (
        .i_addr          (i_addr),
        .i_write_n       (i_write_n),
        .i_read_n        (i_read_n),
        .i_data_busy     (data_busy),
        .i_gpio_data     (gpio_data),
        .i_gpio_ready    (gpio_ready),
        .i_timer_data    (timer_data),
        .i_timer_ready   (timer_ready),
        .i_edge_data     (edge_data),
        .i_pwm_data      (pwm_data),
        .o_gpio_write_n  (gpio_write_n),
        .o_gpio_read_n   (gpio_read_n),
        .o_timer_write_n (timer_write_n),
        .o_timer_read_n  (timer_read_n),
        .o_edge_write    (edge_write),
        .o_pwm_write     (pwm_write),
        .o_periph_data   (periph_data),
        .o_periph_ready  (periph_ready)
    );

    periph_read_buffer u_read_buffer (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_periph_data   (periph_data),
        .i_periph_ready  (periph_ready),
        .i_read_n        (i_read_n),
        .i_write_n       (i_write_n),
        .i_read_complete (i_read_complete),
        .o_data          (o_data),
        .o_data_ready    (o_data_ready),
        .o_data_busy     (data_busy)
    );

    gpio_ctrl u_gpio (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_offset       (i_addr[5:0]),
        .i_data         (i_data),
        .i_write_n      (gpio_write_n),
        .i_read_n       (gpio_read_n),
        .i_ui_in        (i_ui_in),
        .i_timer_pins   (timer_pins),
        .i_edge_pins    (edge_pins),
        .i_pwm_pins     (pwm_pins),
        .o_data         (gpio_data),
        .o_data_ready   (gpio_ready),
        .o_uo_out       (o_uo_out),
        .o_audio        (o_audio),
        .o_audio_select (o_audio_select)
    );

    timer_periph u_timer (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_offset     (i_addr[5:0]),
        .i_data       (i_data),
        .i_write_n    (timer_write_n),
        .i_read_n     (timer_read_n),
        .o_data       (timer_data),
        .o_data_ready (timer_ready),
        .o_pins       (timer_pins),
        .o_irq        (o_irq)
    );

    edge_counter_periph u_edge (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_offset (i_addr[3:0]),
        .i_data   (i_data[7:0]),
        .i_write  (edge_write),
        .i_ui_in  (i_ui_in),
        .o_data   (edge_data),
        .o_pins   (edge_pins)
    );

    pwm_periph u_pwm (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_offset (i_addr[3:0]),
        .i_data   (i_data[7:0]),
        .i_write  (pwm_write),
        .o_data   (pwm_data),
        .o_pins   (pwm_pins)
    );

endmodule

/* source/pwm_periph.sv */
module pwm_periph
    import periph_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [3:0] i_offset,
    input  logic [7:0] i_data,
    input  logic       i_write,
    output logic [7:0] o_data,
    output logic [7:0] o_pins
);

    logic [7:0] duty;
    logic [7:0] counter;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            duty    <= '0;
            counter <= '0;
        end else begin
            // Period of 255 cycles so a duty of 255 stays high
            if (counter == PWM_TOP) begin
                counter <= '0;
            end else begin
                counter <= counter + 1'b1;
            end
            if (i_write && i_offset == PWM_OFS_DUTY) begin
                duty <= i_data;
            end
        end
    end

    assign o_data = (i_offset == PWM_OFS_DUTY) ? duty : 8'h00;
    assign o_pins = {7'h00, counter < duty};

endmodule

/* source/edge_counter_periph.sv */
module edge_counter_periph
    import periph_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [3:0] i_offset,
    input  logic [7:0] i_data,
    input  logic       i_write,
    input  logic [7:0] i_ui_in,
    output logic [7:0] o_data,
    output logic [7:0] o_pins
);

    logic [2:0] pin_sel;
    logic [7:0] count;
    logic       prev;
    logic       pulse;
    logic       rise;

    assign rise = i_ui_in[pin_sel] && !prev;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pin_sel <= '0;
            count   <= '0;
            prev    <= 1'b0;
            pulse   <= 1'b0;
        end else begin
            prev  <= i_ui_in[pin_sel];
            pulse <= rise;
            if (rise) begin
                count <= count + 1'b1;
            end
            if (i_write && i_offset == EDGE_OFS_SEL) begin
                pin_sel <= i_data[2:0];
            end
            if (i_write && i_offset == EDGE_OFS_COUNT) begin
                count <= '0;              // Clear beats a same-cycle edge
            end
        end
    end

    assign o_data = (i_offset == EDGE_OFS_SEL)   ? {5'b0, pin_sel} :
                    (i_offset == EDGE_OFS_COUNT) ? count : 8'h00;

    assign o_pins = {7'h00, pulse};

endmodule

/* source/timer_periph.sv */
module timer_periph
    import periph_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [5:0]        i_offset,
    input  logic [DATA_W-1:0] i_data,
    input  logic [1:0]        i_write_n,
    input  logic [1:0]        i_read_n,
    output logic [DATA_W-1:0] o_data,
    output logic              o_data_ready,
    output logic [7:0]        o_pins,
    output logic              o_irq
);

    logic              enable;
    logic [DATA_W-1:0] compare;
    logic [DATA_W-1:0] count;
    logic              match_pin;
    logic              write_req;
    logic              read_req;
    logic              match;

    assign write_req = i_write_n != SIZE_NONE;
    assign read_req  = i_read_n != SIZE_NONE;
    assign match     = enable && (count == compare);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable       <= 1'b0;
            compare      <= '0;
            count        <= '0;
            match_pin    <= 1'b0;
            o_irq        <= 1'b0;
            o_data_ready <= 1'b0;
        end else begin
            if (enable) begin
                count <= count + 1'b1;
            end
            if (match) begin
                o_irq     <= 1'b1;        // Sticky until cleared
                match_pin <= ~match_pin;
            end
            // Bus writes take priority over the counter
            if (write_req) begin
                case (i_offset)
                    TIMER_OFS_CTRL: begin
                        enable <= i_data[0];
                        if (i_data[1]) begin
                            o_irq <= 1'b0;
                        end
                    end
                    TIMER_OFS_CMP:   compare <= i_data;
                    TIMER_OFS_COUNT: count   <= '0;
                    default: ;
                endcase
            end
            o_data_ready <= read_req;
        end
    end

    always_ff @(posedge clk) begin
        if (read_req) begin
            case (i_offset)
                TIMER_OFS_CTRL:  o_data <= DATA_W'({o_irq, enable});
                TIMER_OFS_CMP:   o_data <= compare;
                TIMER_OFS_COUNT: o_data <= count;
                default:         o_data <= '0;
            endcase
        end
    end

    assign o_pins = {match_pin, 7'h00};

endmodule

/* source/gpio_ctrl.sv */
module gpio_ctrl
    import periph_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [5:0]        i_offset,
    input  logic [DATA_W-1:0] i_data,
    input  logic [1:0]        i_write_n,
    input  logic [1:0]        i_read_n,
    input  logic [7:0]        i_ui_in,
    input  logic [7:0]        i_timer_pins,
    input  logic [7:0]        i_edge_pins,
    input  logic [7:0]        i_pwm_pins,
    output logic [DATA_W-1:0] o_data,
    output logic              o_data_ready,
    output logic [7:0]        o_uo_out,
    output logic              o_audio,
    output logic              o_audio_select
);

    logic [7:0] gpio_out;
    logic [3:0] audio_sel;        // Enable bit over source code
    logic [2:0] func_sel [8];
    logic       write_req;
    logic       func_hit;
    logic [2:0] func_idx;

    assign write_req = i_write_n != SIZE_NONE;

    // Function registers sit on word boundaries from the base
    assign func_hit = (i_offset & 6'h23) == GPIO_OFS_FUNC_BASE;
    assign func_idx = i_offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out  <= '0;
            audio_sel <= '0;
            for (int i = 0; i < 8; i++) begin
                func_sel[i] <= FUNC_GPIO;
            end
        end else if (write_req) begin
            if (i_offset == GPIO_OFS_OUT) begin
                gpio_out <= i_data[7:0];
            end
            if (i_offset == GPIO_OFS_AUDIO) begin
                audio_sel <= i_data[3:0];
            end
            if (func_hit) begin
                func_sel[func_idx] <= i_data[2:0];
            end
        end
    end

    always_comb begin
        o_data = '0;
        if (i_offset == GPIO_OFS_OUT) begin
            o_data = DATA_W'(gpio_out);
        end else if (i_offset == GPIO_OFS_IN) begin
            o_data = DATA_W'(i_ui_in);
        end else if (i_offset == GPIO_OFS_AUDIO) begin
            o_data = DATA_W'(audio_sel);
        end else if (func_hit) begin
            o_data = DATA_W'(func_sel[func_idx]);
        end
    end

    assign o_data_ready = i_read_n != SIZE_NONE;   // Registers answer at once

    // Each pin takes the same bit from its selected source
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            case (func_sel[i])
                FUNC_GPIO:  o_uo_out[i] = gpio_out[i];
                FUNC_TIMER: o_uo_out[i] = i_timer_pins[i];
                FUNC_EDGE:  o_uo_out[i] = i_edge_pins[i];
                FUNC_PWM:   o_uo_out[i] = i_pwm_pins[i];
                default:    o_uo_out[i] = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (audio_sel[2:0])
            AUDIO_SRC_PWM:   o_audio <= i_pwm_pins[0];
            AUDIO_SRC_TIMER: o_audio <= i_timer_pins[7];
            default:         o_audio <= 1'b0;
        endcase
    end

    assign o_audio_select = audio_sel[3];

endmodule

/* source/periph_read_buffer.sv */
module periph_read_buffer
    import periph_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [DATA_W-1:0] i_periph_data,
    input  logic              i_periph_ready,
    input  logic [1:0]        i_read_n,
    input  logic [1:0]        i_write_n,
    input  logic              i_read_complete,
    output logic [DATA_W-1:0] o_data,
    output logic              o_data_ready,
    output logic              o_data_busy
);

    logic [DATA_W-1:0] data_r;
    logic              hold;
    logic              ready_r;
    logic              capture;

    // First ready cycle of a read while nothing is held
    assign capture = (i_read_n != SIZE_NONE) && i_periph_ready && !hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold <= 1'b0;
            end
            if (capture) begin
                hold <= 1'b1;
            end
            ready_r <= capture;   // Lines up with the registered data
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_r <= i_periph_data;
        end
    end

    assign o_data       = data_r;
    assign o_data_ready = ready_r || (i_write_n != SIZE_NONE);
    assign o_data_busy  = hold;

endmodule

/* source/periph_bus_decode.sv */
module periph_bus_decode
    import periph_pkg::*;
(
    input  periph_addr_t      i_addr,
    input  logic [1:0]        i_write_n,
    input  logic [1:0]        i_read_n,
    input  logic              i_data_busy,
    input  logic [DATA_W-1:0] i_gpio_data,
    input  logic              i_gpio_ready,
    input  logic [DATA_W-1:0] i_timer_data,
    input  logic              i_timer_ready,
    input  logic [7:0]        i_edge_data,
    input  logic [7:0]        i_pwm_data,
    output logic [1:0]        o_gpio_write_n,
    output logic [1:0]        o_gpio_read_n,
    output logic [1:0]        o_timer_write_n,
    output logic [1:0]        o_timer_read_n,
    output logic              o_edge_write,
    output logic              o_pwm_write,
    output logic [DATA_W-1:0] o_periph_data,
    output logic              o_periph_ready
);

    logic                      is_byte;
    logic                      is_full;
    logic [NUM_FULL_SLOTS-1:0] full_sel;
    logic [NUM_BYTE_SLOTS-1:0] byte_sel;
    logic [1:0]                read_n_masked;
    logic                      write_req;

    assign is_byte = i_addr.byte_view.region == REGION_BYTE;
    assign is_full = !is_byte && (i_addr.full_view.region == REGION_FULL);

    // One-hot slot select, upper full slots stay unselected
    always_comb begin
        full_sel = '0;
        byte_sel = '0;
        if (is_byte) begin
            byte_sel[i_addr.byte_view.slot] = 1'b1;
        end else if (is_full) begin
            full_sel[i_addr.full_view.slot] = 1'b1;
        end
    end

    // No new read reaches a peripheral while a result is buffered
    assign read_n_masked = i_read_n | {2{i_data_busy}};
    assign write_req     = i_write_n != SIZE_NONE;

    assign o_gpio_write_n  = full_sel[SLOT_GPIO]  ? i_write_n     : SIZE_NONE;
    assign o_gpio_read_n   = full_sel[SLOT_GPIO]  ? read_n_masked : SIZE_NONE;
    assign o_timer_write_n = full_sel[SLOT_TIMER] ? i_write_n     : SIZE_NONE;
    assign o_timer_read_n  = full_sel[SLOT_TIMER] ? read_n_masked : SIZE_NONE;
    assign o_edge_write    = write_req && byte_sel[SLOT_EDGE];
    assign o_pwm_write     = write_req && byte_sel[SLOT_PWM];

    always_comb begin
        o_periph_data  = '0;      // Empty slots read zero
        o_periph_ready = 1'b1;
        if (full_sel[SLOT_GPIO]) begin
            o_periph_data  = i_gpio_data;
            o_periph_ready = i_gpio_ready;
        end else if (full_sel[SLOT_TIMER]) begin
            o_periph_data  = i_timer_data;
            o_periph_ready = i_timer_ready;
        end else if (byte_sel[SLOT_EDGE]) begin
            o_periph_data = {{(DATA_W-8){1'b0}}, i_edge_data};
        end else if (byte_sel[SLOT_PWM]) begin
            o_periph_data = {{(DATA_W-8){1'b0}}, i_pwm_data};
        end
    end

endmodule

/* source/periph_pkg.sv */
package periph_pkg;

    // Bus geometry
    localparam int unsigned ADDR_W = 11;
    localparam int unsigned DATA_W = 32;

    // Access size code for no access
    localparam logic [1:0] SIZE_NONE = 2'b11;

    // Region codes in the top address bits
    localparam logic       REGION_FULL = 1'b0;
    localparam logic [1:0] REGION_BYTE = 2'b10;

    localparam int unsigned NUM_FULL_SLOTS = 16;
    localparam int unsigned NUM_BYTE_SLOTS = 16;

    localparam int unsigned SLOT_GPIO  = 1;   // Full slots
    localparam int unsigned SLOT_TIMER = 2;
    localparam int unsigned SLOT_EDGE  = 0;   // Byte slots
    localparam int unsigned SLOT_PWM   = 1;

    // GPIO register map
    localparam logic [5:0] GPIO_OFS_OUT       = 6'h00;
    localparam logic [5:0] GPIO_OFS_IN        = 6'h04;
    localparam logic [5:0] GPIO_OFS_AUDIO     = 6'h10;
    localparam logic [5:0] GPIO_OFS_FUNC_BASE = 6'h20;

    // Output pin sources
    localparam logic [2:0] FUNC_GPIO  = 3'd0;
    localparam logic [2:0] FUNC_TIMER = 3'd1;
    localparam logic [2:0] FUNC_EDGE  = 3'd2;
    localparam logic [2:0] FUNC_PWM   = 3'd3;

    localparam logic [2:0] AUDIO_SRC_PWM   = 3'd0;
    localparam logic [2:0] AUDIO_SRC_TIMER = 3'd1;

    // Timer register map
    localparam logic [5:0] TIMER_OFS_CTRL  = 6'h00;
    localparam logic [5:0] TIMER_OFS_CMP   = 6'h04;
    localparam logic [5:0] TIMER_OFS_COUNT = 6'h08;

    // Byte peripheral register maps
    localparam logic [3:0] EDGE_OFS_SEL   = 4'h0;
    localparam logic [3:0] EDGE_OFS_COUNT = 4'h1;
    localparam logic [3:0] PWM_OFS_DUTY   = 4'h0;
    localparam logic [7:0] PWM_TOP        = 8'd254;   // Last PWM counter value

    typedef struct packed {
        logic       region;
        logic [3:0] slot;
        logic [5:0] offset;
    } full_addr_t;

    typedef struct packed {
        logic [1:0] region;
        logic       unused;
        logic [3:0] slot;
        logic [3:0] offset;
    } byte_addr_t;

    // Same bus address seen as either region
    typedef union packed {
        full_addr_t full_view;
        byte_addr_t byte_view;
    } periph_addr_t;

endpackage
